/* cfg_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lrelu_cfg.svh"

module cfg_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clken,
  input  logic                  s_valid_config,
  output lrelu_pkg::cfg_phase_t phase,
  output logic                  w_idx,
  output logic                  frame_start
);

  import lrelu_pkg::*;

  cfg_phase_t phase_next;
  logic       cnt, cnt_next;
  logic       beat;

  assign beat = clken && s_valid_config;

  // order is D, A, A, B, B and back to D
  always_comb begin
    phase_next = phase;
    cnt_next   = cnt;
    case (phase)
      PH_D: begin
        phase_next = PH_A;
        cnt_next   = 1'b0;
      end
      PH_A: begin
        if (cnt) begin
          phase_next = PH_B;
          cnt_next   = 1'b0;
        end else begin
          cnt_next = 1'b1;
        end
      end
      PH_B: begin
        if (cnt) begin
          phase_next = PH_D; // frame done
          cnt_next   = 1'b0;
        end else begin
          cnt_next = 1'b1;
        end
      end
      default: begin
        phase_next = PH_D;
        cnt_next   = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= PH_D;
      cnt   <= 1'b0;
    end else if (beat) begin
      phase <= phase_next;
      cnt   <= cnt_next;
    end
  end

  assign w_idx       = cnt;
  assign frame_start = (phase == PH_D); // gated with the beat in the top

endmodule

`default_nettype wire

/* coef_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lrelu_cfg.svh"

module coef_bank (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clken,
  input  logic                     cfg_valid,
  input  lrelu_pkg::cfg_phase_t    phase,
  input  logic                     w_idx,
  input  logic [`LRELU_W_CFG-1:0]  s_data_config,
  input  lrelu_pkg::ptr_t          ptr,
  output lrelu_pkg::coef_t         a_val,
  output lrelu_pkg::coef_t         b_val,
  output lrelu_pkg::coef_t         d_val
);

  import lrelu_pkg::*;

  localparam coef_t UNITY = coef_t'(1 << `LRELU_FRAC);

  coef_t a_mem [`LRELU_DEPTH];
  coef_t b_mem [`LRELU_DEPTH];
  coef_t d_reg;

  coef_t lo_word, hi_word;
  ptr_t  lo_idx, hi_idx;
  logic  wr;

  // low half goes to the even index
  assign lo_word = s_data_config[`LRELU_W_COEF-1:0];
  assign hi_word = s_data_config[`LRELU_W_CFG-1:`LRELU_W_COEF];
  assign lo_idx  = ptr_t'({w_idx, 1'b0});
  assign hi_idx  = ptr_t'({w_idx, 1'b1});

  assign wr = clken && cfg_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `LRELU_DEPTH; i++) begin
        a_mem[i] <= UNITY; // identity scale until configured
        b_mem[i] <= '0;
      end
      d_reg <= '0;
    end else if (wr) begin
      case (phase)
        PH_D: d_reg <= lo_word;
        PH_A: begin
          a_mem[lo_idx] <= lo_word;
          a_mem[hi_idx] <= hi_word;
        end
        PH_B: begin
          b_mem[lo_idx] <= lo_word;
          b_mem[hi_idx] <= hi_word;
        end
        default: ;
      endcase
    end
  end

  // registered read, lines up with stage 1 of the lanes
  always_ff @(posedge clk) begin
    if (clken) begin
      a_val <= a_mem[ptr];
      b_val <= b_mem[ptr];
    end
  end

  assign d_val = d_reg;

endmodule

`default_nettype wire

/* coef_read_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lrelu_cfg.svh"

module coef_read_counter (
  input  logic            clk,
  input  logic            rst,
  input  logic            clken,
  input  logic            s_valid,
  input  logic            cfg_valid,
  input  logic            frame_start,
  output lrelu_pkg::ptr_t ptr
);

  localparam int LAST = `LRELU_DEPTH - 1;

  logic restart;

  // a D beat begins a new frame
  assign restart = cfg_valid && frame_start;

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (clken) begin
      if (restart)
        ptr <= '0;
      else if (s_valid)
        ptr <= (ptr == LAST) ? '0 : ptr + 1'b1; // one index per data beat
    end
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
lrelu_pkg.sv
cfg_sequencer.sv
coef_read_counter.sv
coef_bank.sv
lrelu_lane.sv
lrelu_engine.sv
tb_lrelu_engine.sv

/* lrelu_cfg.svh */
`ifndef LRELU_CFG_SVH
`define LRELU_CFG_SVH

// lanes carried side by side in one data beat
`define LRELU_UNITS 4

// word widths
`define LRELU_W_IN   16
`define LRELU_W_OUT  8
`define LRELU_W_COEF 16

// coefficients are Q7.8
`define LRELU_FRAC 8

// entries in each of the A and B memories
`define LRELU_DEPTH 4

// config beat holds two coefficients
`define LRELU_W_CFG 32

// leaky slope, Q0.8, roughly 0.1
`define LRELU_ALPHA 26

// enabled cycles from accepted beat to m_valid
`define LRELU_LATENCY 4

`endif

/* lrelu_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lrelu_cfg.svh"

module lrelu_engine (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  clken,
  input  logic                                  s_valid,
  input  logic                                  s_user,
  input  logic                                  s_valid_config,
  input  logic [`LRELU_UNITS*`LRELU_W_IN-1:0]   s_data,
  input  logic [`LRELU_W_CFG-1:0]               s_data_config,
  output logic                                  m_valid,
  output logic                                  m_user,
  output logic [`LRELU_UNITS*`LRELU_W_OUT-1:0]  m_data
);

  import lrelu_pkg::*;

  localparam int LAT = `LRELU_LATENCY;

  cfg_phase_t phase;
  logic       w_idx;
  logic       frame_start;
  logic       cfg_valid;
  ptr_t       ptr;
  coef_t      a_val, b_val, d_val;

  logic [LAT-1:0] valid_q;
  logic [LAT-1:0] user_q;

  assign cfg_valid = clken && s_valid_config;

  cfg_sequencer u_cfg_sequencer (
    .clk            (clk),
    .rst            (rst),
    .clken          (clken),
    .s_valid_config (s_valid_config),
    .phase          (phase),
    .w_idx          (w_idx),
    .frame_start    (frame_start)
  );

  coef_read_counter u_coef_read_counter (
    .clk         (clk),
    .rst         (rst),
    .clken       (clken),
    .s_valid     (s_valid),
    .cfg_valid   (cfg_valid),
    .frame_start (frame_start),
    .ptr         (ptr)
  );

  coef_bank u_coef_bank (
    .clk           (clk),
    .rst           (rst),
    .clken         (clken),
    .cfg_valid     (cfg_valid),
    .phase         (phase),
    .w_idx         (w_idx),
    .s_data_config (s_data_config),
    .ptr           (ptr),
    .a_val         (a_val),
    .b_val         (b_val),
    .d_val         (d_val)
  );

  // lane 0 sits in the low bits; user enters stage 1 inside each lane
  for (genvar u = 0; u < `LRELU_UNITS; u++) begin : g_lane
    lrelu_lane u_lrelu_lane (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .lrelu_en (s_user),
      .x        (s_data[u*`LRELU_W_IN +: `LRELU_W_IN]),
      .a_val    (a_val),
      .b_val    (b_val),
      .d_val    (d_val),
      .y        (m_data[u*`LRELU_W_OUT +: `LRELU_W_OUT])
    );
  end

  // sideband follows the lane pipeline
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      user_q  <= '0;
    end else if (clken) begin
      valid_q <= {valid_q[LAT-2:0], s_valid};
      user_q  <= {user_q[LAT-2:0], s_user};
    end
  end

  assign m_valid = valid_q[LAT-1];
  assign m_user  = user_q[LAT-1];

endmodule

`default_nettype wire

/* lrelu_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lrelu_cfg.svh"

module lrelu_lane (
  input  logic             clk,
  input  logic             rst,
  input  logic             clken,
  input  logic             lrelu_en,
  input  lrelu_pkg::din_t  x,
  input  lrelu_pkg::coef_t a_val,
  input  lrelu_pkg::coef_t b_val,
  input  lrelu_pkg::coef_t d_val,
  output lrelu_pkg::dout_t y
);

  localparam int W_PROD  = `LRELU_W_IN + `LRELU_W_COEF;
  localparam int W_T     = W_PROD + 1;          // room for the bias add
  localparam int W_SLOPE = W_T + `LRELU_W_COEF;
  localparam int W_SUM   = W_T + 1;

  localparam logic signed [`LRELU_W_COEF-1:0] ALPHA = `LRELU_ALPHA;
  localparam logic signed [W_SUM-1:0] SAT_HI = (2 ** (`LRELU_W_OUT - 1)) - 1;
  localparam logic signed [W_SUM-1:0] SAT_LO = -(2 ** (`LRELU_W_OUT - 1));

  // stage 1
  logic signed [`LRELU_W_IN-1:0] x1;
  logic                          en1;

  // stage 2
  logic signed [W_PROD-1:0] prod;
  logic signed [W_T-1:0]    t2;
  logic                     en2;

  // stage 3
  logic signed [W_SLOPE-1:0] slope_prod;
  logic signed [W_SLOPE-1:0] slope_shift;
  logic signed [W_T-1:0]     t3;

  // stage 4
  logic signed [W_SUM-1:0] sum;

  assign prod        = x1 * a_val;
  assign slope_prod  = t2 * ALPHA;
  assign slope_shift = slope_prod >>> `LRELU_FRAC; // floor, keeps sign
  assign sum         = t3 + d_val;

  always_ff @(posedge clk) begin
    if (clken) begin
      x1  <= x;
      en1 <= lrelu_en;

      t2  <= (prod >>> `LRELU_FRAC) + b_val;
      en2 <= en1;

      if (en2 && t2[W_T-1])
        t3 <= slope_shift[W_T-1:0]; // leaky side
      else
        t3 <= t2;
    end
  end

  // offset and saturate to the output width
  always_ff @(posedge clk) begin
    if (rst) begin
      y <= '0;
    end else if (clken) begin
      if (sum > SAT_HI)
        y <= SAT_HI[`LRELU_W_OUT-1:0];
      else if (sum < SAT_LO)
        y <= SAT_LO[`LRELU_W_OUT-1:0];
      else
        y <= sum[`LRELU_W_OUT-1:0];
    end
  end

endmodule

`default_nettype wire

/* lrelu_pkg.sv */
`default_nettype none

`include "lrelu_cfg.svh"

package lrelu_pkg;

  // which target the next config beat writes
  typedef enum logic [1:0] {
    PH_D = 2'd0,
    PH_A = 2'd1,
    PH_B = 2'd2
  } cfg_phase_t;

  typedef logic signed [`LRELU_W_COEF-1:0] coef_t;

  typedef logic signed [`LRELU_W_IN-1:0]  din_t;
  typedef logic signed [`LRELU_W_OUT-1:0] dout_t;

  // index into A and B
  typedef logic [$clog2(`LRELU_DEPTH)-1:0] ptr_t;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lrelu_engine -f files.f -o sim_lrelu_engine

out=$(./obj_dir/sim_lrelu_engine)
echo "$out"

if echo "$out" | grep -q "Test passed"; then
  exit 0
fi
exit 1

/* tb_lrelu_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lrelu_cfg.svh"

module tb_lrelu_engine;

  localparam int UNITS  = `LRELU_UNITS;
  localparam int W_IN   = `LRELU_W_IN;
  localparam int W_OUT  = `LRELU_W_OUT;
  localparam int W_COEF = `LRELU_W_COEF;
  localparam int DEPTH  = `LRELU_DEPTH;
  localparam int LAT    = `LRELU_LATENCY;

  localparam int     NUM_TESTS       = 6;
  localparam int     WATCHDOG_CYCLES = NUM_TESTS * 200 + 100;
  localparam longint SAT_MAX         = (1 << (W_OUT - 1)) - 1;
  localparam longint SAT_MIN         = -(SAT_MAX + 1);

  logic                     clk;
  logic                     rst;
  logic                     clken;
  logic                     s_valid;
  logic                     s_user;
  logic                     s_valid_config;
  logic [UNITS*W_IN-1:0]    s_data;
  logic [`LRELU_W_CFG-1:0]  s_data_config;
  logic                     m_valid;
  logic                     m_user;
  logic [UNITS*W_OUT-1:0]   m_data;

  // reference state, mirrors what the config stream has written
  logic signed [W_COEF-1:0] model_a [DEPTH];
  logic signed [W_COEF-1:0] model_b [DEPTH];
  logic signed [W_COEF-1:0] model_d;
  int                       cfg_pos;
  int                       model_ptr;

  logic [UNITS*W_OUT-1:0] exp_data_q [$];
  logic                   exp_user_q [$];
  logic [UNITS*W_OUT-1:0] exp_data;
  logic                   exp_user;
  logic                   exp_have;
  logic [LAT-1:0]         lat_sr; // accepted beats, one bit per enabled cycle

  logic signed [W_COEF-1:0] stim_a [DEPTH];
  logic signed [W_COEF-1:0] stim_b [DEPTH];
  logic [31:0]              rng_state;
  int                       err_count;
  int                       test_err_base;
  int                       failed_tests;

  lrelu_engine u_lrelu_engine (
    .clk            (clk),
    .rst            (rst),
    .clken          (clken),
    .s_valid        (s_valid),
    .s_user         (s_user),
    .s_valid_config (s_valid_config),
    .s_data         (s_data),
    .s_data_config  (s_data_config),
    .m_valid        (m_valid),
    .m_user         (m_user),
    .m_data         (m_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("watchdog expired before the tests completed");
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // wide words mostly saturate, narrow ones land in range
  function automatic logic [W_IN-1:0] rand_word(input bit wide);
    logic [31:0] r;
    r = next_rand();
    if (wide)
      return r[W_IN-1:0];
    return W_IN'(int'(r[8:0]) - 256);
  endfunction

  function automatic logic [UNITS*W_IN-1:0] rand_beat(input bit wide);
    logic [UNITS*W_IN-1:0] beat;
    for (int u = 0; u < UNITS; u++)
      beat[u*W_IN +: W_IN] = rand_word(wide);
    return beat;
  endfunction

  // scale and bias, optional slope, offset, saturate
  function automatic logic [W_OUT-1:0] lane_ref(input logic signed [W_IN-1:0] x,
                                                input logic signed [W_COEF-1:0] a,
                                                input logic signed [W_COEF-1:0] b,
                                                input logic signed [W_COEF-1:0] d,
                                                input logic en);
    longint t;
    t = (longint'(x) * longint'(a)) >>> `LRELU_FRAC;
    t = t + longint'(b);
    if (en && t < 0)
      t = (t * `LRELU_ALPHA) >>> `LRELU_FRAC;
    t = t + longint'(d);
    if (t > SAT_MAX)
      t = SAT_MAX;
    else if (t < SAT_MIN)
      t = SAT_MIN;
    return t[W_OUT-1:0];
  endfunction

  function automatic logic [UNITS*W_OUT-1:0] expected_beat(input logic [UNITS*W_IN-1:0] data,
                                                           input logic user);
    logic [UNITS*W_OUT-1:0] res;
    for (int u = 0; u < UNITS; u++)
      res[u*W_OUT +: W_OUT] = lane_ref(data[u*W_IN +: W_IN], model_a[model_ptr],
                                       model_b[model_ptr], model_d, user);
    return res;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        model_a[i] = W_COEF'(1 << `LRELU_FRAC);
        model_b[i] = '0;
      end
      model_d   = '0;
      cfg_pos   = 0;
      model_ptr = 0;
      exp_data_q.delete();
      exp_user_q.delete();
      lat_sr   <= '0;
      exp_have <= 1'b0;
    end else if (clken) begin
      lat_sr <= {lat_sr[LAT-2:0], s_valid};
      if (m_valid && exp_data_q.size() != 0) begin
        void'(exp_data_q.pop_front());
        void'(exp_user_q.pop_front());
      end
      if (s_valid_config) begin
        case (cfg_pos)
          0: begin
            model_d   = s_data_config[W_COEF-1:0];
            model_ptr = 0; // new frame restarts the read index
          end
          1, 2: begin
            model_a[2*cfg_pos-2] = s_data_config[W_COEF-1:0];
            model_a[2*cfg_pos-1] = s_data_config[2*W_COEF-1:W_COEF];
          end
          default: begin
            model_b[2*cfg_pos-6] = s_data_config[W_COEF-1:0];
            model_b[2*cfg_pos-5] = s_data_config[2*W_COEF-1:W_COEF];
          end
        endcase
        cfg_pos = (cfg_pos == 4) ? 0 : cfg_pos + 1;
      end
      if (s_valid) begin
        exp_data_q.push_back(expected_beat(s_data, s_user));
        exp_user_q.push_back(s_user);
        model_ptr = (model_ptr + 1) % DEPTH;
      end
      exp_have <= (exp_data_q.size() != 0);
      if (exp_data_q.size() != 0) begin
        exp_data <= exp_data_q[0];
        exp_user <= exp_user_q[0];
      end
    end
  end

  a_data: assert property (@(posedge clk) disable iff (rst)
      (clken && m_valid && exp_have) |-> (m_data == exp_data && m_user == exp_user))
    else begin
      err_count++;
      $display("Fail at %0t ns: output %h user %b, expected %h user %b", $time,
               $sampled(m_data), $sampled(m_user), $sampled(exp_data),
               $sampled(exp_user));
    end

  a_latency: assert property (@(posedge clk) disable iff (rst) m_valid == lat_sr[LAT-1])
    else begin
      err_count++;
      $display("Fail at %0t ns: m_valid is %b, expected %b", $time,
               $sampled(m_valid), $sampled(lat_sr[LAT-1]));
    end

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    clken          = 1'b1;
    s_valid        = 1'b0;
    s_valid_config = 1'b0;
  endtask

  // holds the beat until an enabled edge takes it
  task automatic drive_beat(input logic user, input logic [UNITS*W_IN-1:0] data,
                            input bit stall);
    bit en;
    do begin
      en = stall ? ((next_rand() & 32'd3) != 0) : 1'b1;
      @(posedge clk);
      #1;
      clken          = en;
      s_valid        = 1'b1;
      s_user         = user;
      s_data         = data;
      s_valid_config = 1'b0;
    end while (!en);
  endtask

  task automatic cfg_beat(input logic [`LRELU_W_CFG-1:0] word);
    @(posedge clk);
    #1;
    clken          = 1'b1;
    s_valid        = 1'b0;
    s_valid_config = 1'b1;
    s_data_config  = word;
  endtask

  task automatic send_config(input logic [W_COEF-1:0] d);
    cfg_beat({{W_COEF{1'b0}}, d});
    cfg_beat({stim_a[1], stim_a[0]});
    cfg_beat({stim_a[3], stim_a[2]});
    cfg_beat({stim_b[1], stim_b[0]});
    cfg_beat({stim_b[3], stim_b[2]});
    idle_cycle();
  endtask

  task automatic random_config();
    logic [31:0] r;
    for (int i = 0; i < DEPTH; i++) begin
      r = next_rand();
      stim_a[i] = W_COEF'(int'(r[9:0]) - 384);
      stim_b[i] = W_COEF'(int'(r[25:16]) - 512);
    end
    r = next_rand();
    send_config(W_COEF'(int'(r[7:0]) - 128));
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < 4 * LAT + 8) begin
      idle_cycle();
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      err_count++;
      $display("%0d output beats never appeared", exp_data_q.size());
    end
    repeat (2) idle_cycle();
  endtask

  task automatic finish_test(input int num, input string name);
    drain();
    if (err_count == test_err_base) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", num, name, err_count - test_err_base);
    end
    test_err_base = err_count;
  endtask

  initial begin
    rst            = 1'b1;
    clken          = 1'b1;
    s_valid        = 1'b0;
    s_user         = 1'b0;
    s_valid_config = 1'b0;
    s_data         = '0;
    s_data_config  = '0;
    rng_state      = 32'd47654;
    err_count      = 0;
    test_err_base  = 0;
    failed_tests   = 0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    repeat (4) idle_cycle(); // m_valid must stay low here
    for (int i = 0; i < 12; i++)
      drive_beat(1'b0, rand_beat(i[0]), 1'b0);
    finish_test(1, "reset defaults");

    random_config();
    for (int i = 0; i < 40; i++)
      drive_beat(1'b0, rand_beat(1'b0), 1'b0);
    finish_test(2, "configured, no slope");

    random_config();
    for (int i = 0; i < 40; i++)
      drive_beat(1'b1, rand_beat(1'b0), 1'b0);
    finish_test(3, "leaky slope");

    stim_a[0] = 16'sd256;
    stim_a[1] = 16'sd512;
    stim_a[2] = -16'sd128;
    stim_a[3] = 16'sd64;
    stim_b[0] = 16'sd0;
    stim_b[1] = 16'sd20;
    stim_b[2] = -16'sd40;
    stim_b[3] = 16'sd60;
    send_config(16'sd5);
    for (int i = 0; i < 8; i++)
      drive_beat(1'b0, rand_beat(1'b0), 1'b0);
    finish_test(4, "cyclic coefficients");

    for (int i = 0; i < 60; i++)
      drive_beat(next_rand() & 32'd1, rand_beat(1'b0), 1'b1);
    finish_test(5, "clken stalls");

    // leave the pointer off zero before the new frame
    for (int i = 0; i < 3; i++)
      drive_beat(1'b0, rand_beat(1'b0), 1'b0);
    drain(); // pipeline empty before the config frame
    random_config();
    for (int i = 0; i < 12; i++)
      drive_beat(next_rand() & 32'd1, rand_beat(1'b0), 1'b0);
    finish_test(6, "reconfiguration");

    $display("tests run %0d, tests failing %0d, errors %0d", NUM_TESTS, failed_tests,
             err_count);
    if (err_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
